// ==== common/mem_pkg.sv ====
package mem_pkg;

    localparam int unsigned data_w        = 16;         // processor word
    localparam int unsigned addr_w        = 18;         // sram address lines
    localparam int unsigned pc_w          = 16;
    localparam int unsigned num_banks     = 2;
    localparam int unsigned inst_bank     = 1;          // bank that serves fetch
    localparam int unsigned low_limit     = 'h8000;     // bank 0 starts here
    localparam int unsigned com_data_addr = 'hBF00;     // serial data register
    localparam int unsigned com_stat_addr = 'hBF01;     // serial status register

    typedef enum logic
    {
        op_rd = 1'b0,
        op_wr = 1'b1
    } mem_op_e;

    typedef enum logic
    {
        com_idle = 1'b0,
        com_busy = 1'b1
    } com_state_e;

    typedef enum logic [1:0]
    {
        src_bank0    = 2'd0,
        src_bank1    = 2'd1,
        src_com_data = 2'd2,
        src_com_stat = 2'd3
    } rd_src_e;

    // one bank request, as decoded from the processor side
    typedef struct packed
    {
        logic              ce;      // select the chip
        logic              we;      // write cycle
        logic              drive;   // wdata onto the data pins
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
    } bank_req_t;

    typedef struct packed
    {
        logic              ce_n;
        logic              oe_n;
        logic              we_n;
        logic [addr_w-1:0] addr;
    } sram_pins_t;

    typedef struct packed
    {
        logic sel;    // serial data access this cycle
        logic we;
        logic stat;   // status read
    } com_req_t;

endpackage

// ==== design/bank_decoder.sv ====
`timescale 1ns/1ps

module bank_decoder
    import mem_pkg::*;
(
    input  logic              en,
    input  mem_op_e           op,
    input  logic [addr_w-1:0] addr,
    input  logic [pc_w-1:0]   pc,
    input  logic [data_w-1:0] data_i,
    output bank_req_t         bank_req [num_banks],
    output com_req_t          com_req,
    output rd_src_e           rd_src,
    output logic              conflict
);

    logic is_stat;
    logic is_com_data;
    logic is_low;
    logic is_high;
    logic is_wr;

    assign is_wr       = (op == op_wr);
    assign is_stat     = en && (addr == addr_w'(com_stat_addr));
    assign is_com_data = en && (addr == addr_w'(com_data_addr));
    assign is_low      = en && (addr < addr_w'(low_limit));   // steals the fetch bank
    assign is_high     = en && !is_low && !is_stat && !is_com_data;

    // fetch bank, data access overrides the program counter
    always_comb
    begin
        if (is_low)
        begin
            bank_req[inst_bank].ce    = 1'b1;
            bank_req[inst_bank].we    = is_wr;
            bank_req[inst_bank].drive = is_wr;
            bank_req[inst_bank].addr  = addr;
        end
        else
        begin
            bank_req[inst_bank].ce    = 1'b1;                 // fetch always reads
            bank_req[inst_bank].we    = 1'b0;
            bank_req[inst_bank].drive = 1'b0;
            bank_req[inst_bank].addr  = addr_w'(pc);          // zero-extended
        end
        bank_req[inst_bank].wdata = data_i;
    end

    // bank 0 also carries the serial byte on its data pins
    always_comb
    begin
        bank_req[0].ce    = is_high;
        bank_req[0].we    = is_high && is_wr;
        bank_req[0].drive = (is_high || is_com_data) && is_wr;   // chip stays off for serial
        bank_req[0].addr  = addr;
        bank_req[0].wdata = data_i;
    end

    assign com_req.sel  = is_com_data;
    assign com_req.we   = is_wr;
    assign com_req.stat = is_stat;

    always_comb
    begin
        if (is_low)
            rd_src = src_bank1;
        else if (is_com_data)
            rd_src = src_com_data;
        else if (is_stat)
            rd_src = src_com_stat;
        else
            rd_src = src_bank0;
    end

    assign conflict = is_low;

endmodule

// ==== design/mem_ctrl_top.sv ====
`timescale 1ns/1ps

module mem_ctrl_top
    import mem_pkg::*;
(
    input  logic              clk_50mhz,
    input  logic              rst_n,

    // processor side
    input  logic              en,
    input  mem_op_e           op,
    input  logic [addr_w-1:0] addr,
    input  logic [data_w-1:0] data_i,
    input  logic [pc_w-1:0]   pc,
    output logic [data_w-1:0] data_o,
    output logic [data_w-1:0] inst,
    output logic              ram_pause,

    // serial device
    input  logic              data_ready,
    input  logic              tbre,
    input  logic              tsre,
    output logic              rdn,
    output logic              wrn,

    // sram chips, split data lines
    input  logic [data_w-1:0] sram_data_in  [num_banks],
    output sram_pins_t        sram_pins     [num_banks],
    output logic [data_w-1:0] sram_data_out [num_banks],
    output logic              sram_data_oe  [num_banks]
);

    bank_req_t         bank_req   [num_banks];
    logic [data_w-1:0] bank_rdata [num_banks];
    com_req_t          com_req;
    rd_src_e           rd_src;
    logic              conflict;
    logic              com_pause;
    logic [data_w-1:0] status;

    bank_decoder u_decoder (
        .en       (en),
        .op       (op),
        .addr     (addr),
        .pc       (pc),
        .data_i   (data_i),
        .bank_req (bank_req),
        .com_req  (com_req),
        .rd_src   (rd_src),
        .conflict (conflict)
    );

    for (genvar i = 0; i < num_banks; i++)
    begin : g_bank
        sram_bank_ctrl u_bank (
            .clk_50mhz (clk_50mhz),
            .bank_req  (bank_req[i]),
            .data_in   (sram_data_in[i]),
            .pins      (sram_pins[i]),
            .data_out  (sram_data_out[i]),
            .data_oe   (sram_data_oe[i]),
            .rdata     (bank_rdata[i])
        );
    end

    serial_port_ctrl u_serial (
        .clk_50mhz  (clk_50mhz),
        .rst_n      (rst_n),
        .com_req    (com_req),
        .data_ready (data_ready),
        .tbre       (tbre),
        .tsre       (tsre),
        .rdn        (rdn),
        .wrn        (wrn),
        .com_pause  (com_pause),
        .status     (status)
    );

    read_mux u_read_mux (
        .bank_rdata (bank_rdata),
        .status     (status),
        .rd_src     (rd_src),
        .conflict   (conflict),
        .com_pause  (com_pause),
        .data_o     (data_o),
        .inst       (inst),
        .ram_pause  (ram_pause)
    );

endmodule

// ==== design/read_mux.sv ====
`timescale 1ns/1ps

module read_mux
    import mem_pkg::*;
(
    input  logic [data_w-1:0] bank_rdata [num_banks],
    input  logic [data_w-1:0] status,
    input  rd_src_e           rd_src,
    input  logic              conflict,    // data access holds the fetch bank
    input  logic              com_pause,
    output logic [data_w-1:0] data_o,
    output logic [data_w-1:0] inst,
    output logic              ram_pause
);

    always_comb
    begin
        case (rd_src)
            src_bank0:
                data_o = bank_rdata[0];
            src_bank1:
                data_o = bank_rdata[1];
            src_com_data:
                data_o = bank_rdata[0];   // serial byte shares the bank 0 lines
            src_com_stat:
                data_o = status;
            default:
                data_o = bank_rdata[0];
        endcase
    end

    // not valid while conflict is high
    assign inst      = bank_rdata[inst_bank];

    assign ram_pause = conflict || com_pause;

endmodule

// ==== files.f ====
common/mem_pkg.sv
design/bank_decoder.sv
sram_bank/sram_bank_ctrl.sv
serial_port/serial_port_ctrl.sv
design/read_mux.sv
design/mem_ctrl_top.sv
verification/sram_model.sv
verification/mem_ctrl_checker.sv
verification/mem_ctrl_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the memory controller testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -f files.f --top-module mem_ctrl_tb -Mdir obj_dir &&
{ ./obj_dir/Vmem_ctrl_tb | tee /dev/stderr | grep -q "ALL TESTS PASSED"; } &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

// ==== serial_port/serial_port_ctrl.sv ====
`timescale 1ns/1ps

module serial_port_ctrl
    import mem_pkg::*;
(
    input  logic              clk_50mhz,
    input  logic              rst_n,
    input  com_req_t          com_req,
    input  logic              data_ready,   // a byte is waiting
    input  logic              tbre,
    input  logic              tsre,
    output logic              rdn,
    output logic              wrn,
    output logic              com_pause,
    output logic [data_w-1:0] status
);

    com_state_e state;
    logic       busy;

    // two-cycle sequence, first cycle pauses the processor
    always_ff @(posedge clk_50mhz or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= com_idle;
        end
        else
        begin
            case (state)
                com_idle:
                begin
                    if (com_req.sel)
                        state <= com_busy;
                end
                com_busy:
                begin
                    state <= com_idle;   // access done
                end
                default:
                begin
                    state <= com_idle;
                end
            endcase
        end
    end

    assign busy      = (state == com_busy) && com_req.sel;
    assign com_pause = (state == com_idle) && com_req.sel;

    // read strobe only if the device has something for us
    assign rdn = ~(busy && !com_req.we && data_ready);

    // write strobe in the low clock phase of the second cycle
    assign wrn = ~(busy && com_req.we && !clk_50mhz);

    // flags only show during a status read
    always_comb
    begin
        status = '0;
        if (com_req.stat)
        begin
            status[0] = tbre && tsre;   // ready to send
            status[1] = data_ready;
        end
    end

endmodule

// ==== sram_bank/sram_bank_ctrl.sv ====
`timescale 1ns/1ps

module sram_bank_ctrl
    import mem_pkg::*;
(
    input  logic              clk_50mhz,
    input  bank_req_t         bank_req,
    input  logic [data_w-1:0] data_in,    // from the chip data lines
    output sram_pins_t        pins,
    output logic [data_w-1:0] data_out,
    output logic              data_oe,
    output logic [data_w-1:0] rdata
);

    // control pins are all active low; idle means everything high
    always_comb
    begin
        pins.ce_n = 1'b1;
        pins.oe_n = 1'b1;
        pins.we_n = 1'b1;
        pins.addr = bank_req.addr;

        if (bank_req.ce)
        begin
            pins.ce_n = 1'b0;
            if (bank_req.we)
            begin
                pins.oe_n = 1'b1;          // chip must not drive during write
                pins.we_n = ~clk_50mhz;    // strobe only in the high phase
            end
            else
            begin
                pins.oe_n = 1'b0;          // async read, data same cycle
            end
        end
    end

    // write data, also used for the serial byte on bank 0
    assign data_out = bank_req.wdata;
    assign data_oe  = bank_req.drive;

    // read back whatever sits on the lines, sram or serial device
    assign rdata    = data_in;

endmodule

// ==== verification/mem_ctrl_checker.sv ====
`timescale 1ns/1ps

module mem_ctrl_checker
    import mem_pkg::*;
(
    input  logic              clk_50mhz,
    input  logic              rst_n,
    input  logic [data_w-1:0] data_o,
    input  logic [data_w-1:0] inst,
    input  logic              ram_pause,
    input  logic              rdn,
    input  logic              wrn,
    input  logic              ce0_n,
    input  logic              chk_on,      // compare at the coming rising edge
    input  logic              chk_data,
    input  logic              chk_inst,
    input  logic              exp_pause,
    input  logic [data_w-1:0] exp_data,
    input  logic [data_w-1:0] exp_inst,
    output int                error_count,
    output int                failed_tests,
    output int                run_tests
);

    int cyc_errors  = 0;
    int call_errors = 0;
    int rd_pulses   = 0;
    int wr_pulses   = 0;
    int ce0_lows    = 0;
    int err_mark    = 0;
    int rd_mark     = 0;
    int wr_mark     = 0;
    int ce0_mark    = 0;

    initial
    begin
        failed_tests = 0;
        run_tests    = 0;
    end

    assign error_count = cyc_errors + call_errors;

    always @(posedge clk_50mhz)
    begin
        if (rst_n && chk_on)
        begin
            if (ram_pause !== exp_pause)
            begin
                cyc_errors++;
                $display("FAILED at %0t: ram_pause %0b, expected %0b",
                         $time, ram_pause, exp_pause);
            end
            if (chk_data && data_o !== exp_data)
            begin
                cyc_errors++;
                $display("FAILED at %0t: data_o %h, expected %h", $time, data_o, exp_data);
            end
            if (chk_inst && inst !== exp_inst)
            begin
                cyc_errors++;
                $display("FAILED at %0t: inst %h, expected %h", $time, inst, exp_inst);
            end
        end
    end

    always @(negedge rdn) rd_pulses++;
    always @(negedge wrn) wr_pulses++;

    always @(posedge clk_50mhz)
    begin
        if (rst_n && !ce0_n)
            ce0_lows++;   // bank 0 chip selected this cycle
    end

    task automatic compare_word(input string what, input logic [data_w-1:0] got,
                                input logic [data_w-1:0] exp);
        if (got !== exp)
        begin
            call_errors++;
            $display("FAILED at %0t: %s %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_strobes(input int exp_rd, input int exp_wr, input bit no_ce0);
        if (rd_pulses - rd_mark != exp_rd || wr_pulses - wr_mark != exp_wr)
        begin
            call_errors++;
            $display("FAILED at %0t: %0d rdn and %0d wrn pulses, expected %0d and %0d",
                     $time, rd_pulses - rd_mark, wr_pulses - wr_mark, exp_rd, exp_wr);
        end
        if (no_ce0 && ce0_lows != ce0_mark)
        begin
            call_errors++;
            $display("FAILED at %0t: bank 0 chip enable went low %0d times",
                     $time, ce0_lows - ce0_mark);
        end
    endtask

    task automatic start_test();
        err_mark = cyc_errors + call_errors;
        rd_mark  = rd_pulses;
        wr_mark  = wr_pulses;
        ce0_mark = ce0_lows;
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = cyc_errors + call_errors - err_mark;
        run_tests++;
        if (errs != 0)
            failed_tests++;
        $display("test %0d %s: %s, %0d errors", run_tests, name,
                 (errs != 0) ? "failed" : "ok", errs);
    endtask

endmodule

// ==== verification/mem_ctrl_tb.sv ====
`timescale 1ns/1ps

module mem_ctrl_tb
    import mem_pkg::*;
;

    localparam int num_tests = 6;
    localparam int n_rand    = 16;

    typedef struct packed
    {
        rd_src_e           target;
        logic              pause;    // expected in the first cycle
        logic [data_w-1:0] word;
    } ref_t;

    logic              clk_50mhz = 1'b0;
    logic              rst_n;
    logic              en;
    mem_op_e           op;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data_i;
    logic [pc_w-1:0]   pc;
    logic [data_w-1:0] data_o;
    logic [data_w-1:0] inst;
    logic              ram_pause;
    logic              data_ready;
    logic              tbre;
    logic              tsre;
    logic              rdn;
    logic              wrn;
    logic [7:0]        com_byte;
    logic [data_w-1:0] com_wr_data;
    logic [data_w-1:0] unused_wr_data;

    logic [data_w-1:0] sram_data_in  [num_banks];
    sram_pins_t        sram_pins     [num_banks];
    logic [data_w-1:0] sram_data_out [num_banks];
    logic              sram_data_oe  [num_banks];

    logic              chk_on;
    logic              chk_data;
    logic              chk_inst;
    logic              exp_pause;
    logic [data_w-1:0] exp_data;
    logic [data_w-1:0] exp_inst;
    int                error_count;
    int                failed_tests;
    int                run_tests;

    logic [data_w-1:0] shadow0 [int];
    logic [data_w-1:0] shadow1 [int];
    logic [addr_w-1:0] addrs   [$];

    always #10 clk_50mhz = ~clk_50mhz;

    mem_ctrl_top mem_ctrl_top_i (
        .clk_50mhz     (clk_50mhz),
        .rst_n         (rst_n),
        .en            (en),
        .op            (op),
        .addr          (addr),
        .data_i        (data_i),
        .pc            (pc),
        .data_o        (data_o),
        .inst          (inst),
        .ram_pause     (ram_pause),
        .data_ready    (data_ready),
        .tbre          (tbre),
        .tsre          (tsre),
        .rdn           (rdn),
        .wrn           (wrn),
        .sram_data_in  (sram_data_in),
        .sram_pins     (sram_pins),
        .sram_data_out (sram_data_out),
        .sram_data_oe  (sram_data_oe)
    );

    sram_model #(.bank(0), .has_com(1'b1)) sram0 (
        .pins        (sram_pins[0]),
        .data_out    (sram_data_out[0]),
        .data_oe     (sram_data_oe[0]),
        .data_in     (sram_data_in[0]),
        .rdn         (rdn),
        .wrn         (wrn),
        .com_byte    (com_byte),
        .com_wr_data (com_wr_data)
    );

    sram_model #(.bank(1), .has_com(1'b0)) sram1 (
        .pins        (sram_pins[1]),
        .data_out    (sram_data_out[1]),
        .data_oe     (sram_data_oe[1]),
        .data_in     (sram_data_in[1]),
        .rdn         (1'b1),
        .wrn         (1'b1),
        .com_byte    (8'h00),
        .com_wr_data (unused_wr_data)
    );

    mem_ctrl_checker checker_i (
        .clk_50mhz    (clk_50mhz),
        .rst_n        (rst_n),
        .data_o       (data_o),
        .inst         (inst),
        .ram_pause    (ram_pause),
        .rdn          (rdn),
        .wrn          (wrn),
        .ce0_n        (sram_pins[0].ce_n),
        .chk_on       (chk_on),
        .chk_data     (chk_data),
        .chk_inst     (chk_inst),
        .exp_pause    (exp_pause),
        .exp_data     (exp_data),
        .exp_inst     (exp_inst),
        .error_count  (error_count),
        .failed_tests (failed_tests),
        .run_tests    (run_tests)
    );

    // power-up contents of each chip
    function automatic logic [data_w-1:0] fill_word(input int bank, input logic [addr_w-1:0] a);
        logic [data_w-1:0] salt;
        salt = (bank == 0) ? 16'h3c5a : 16'hc3a5;
        return a[15:0] ^ {a[1:0], a[17:4]} ^ salt;
    endfunction

    function automatic logic [data_w-1:0] shadow_rd(input int bank, input logic [addr_w-1:0] a);
        int idx;
        idx = int'(a);
        if (bank == 0)
            return shadow0.exists(idx) ? shadow0[idx] : fill_word(0, a);
        return shadow1.exists(idx) ? shadow1[idx] : fill_word(1, a);
    endfunction

    // address map of the processor, updates the shadows on writes
    function automatic ref_t ref_access(input logic e, input mem_op_e o,
                                        input logic [addr_w-1:0] a,
                                        input logic [pc_w-1:0] p, input logic [data_w-1:0] d);
        ref_t r;
        r.target = src_bank0;
        r.pause  = 1'b0;
        r.word   = '0;
        if (!e)
        begin
            r.target = src_bank1;
            r.word   = shadow_rd(1, {2'b00, p});   // plain fetch
        end
        else if (a < 18'h08000)
        begin
            r.target = src_bank1;
            r.pause  = 1'b1;
            if (o == op_wr)
                shadow1[int'(a)] = d;
            r.word = shadow_rd(1, a);
        end
        else if (a == 18'h0BF00)
        begin
            r.target = src_com_data;
            r.pause  = 1'b1;
            r.word   = {8'h00, com_byte};
        end
        else if (a == 18'h0BF01)
        begin
            r.target = src_com_stat;
            r.word   = {14'b0, data_ready, tbre && tsre};
        end
        else
        begin
            if (o == op_wr)
                shadow0[int'(a)] = d;
            r.word = shadow_rd(0, a);
        end
        return r;
    endfunction

    // one processor access, held two cycles for the serial data register
    task automatic access(input logic e, input mem_op_e o, input logic [addr_w-1:0] a,
                          input logic [data_w-1:0] d, input logic [pc_w-1:0] p);
        ref_t r;
        @(negedge clk_50mhz);
        r         = ref_access(e, o, a, p, d);
        en        = e;
        op        = o;
        addr      = a;
        data_i    = d;
        pc        = p;
        chk_on    = 1'b1;
        exp_pause = r.pause;
        chk_data  = e && (o == op_rd) && (r.target != src_com_data);
        chk_inst  = !e;
        exp_data  = r.word;
        exp_inst  = r.word;
        @(posedge clk_50mhz);
        if (e && r.target == src_com_data)
        begin
            @(negedge clk_50mhz);
            exp_pause = 1'b0;
            chk_data  = (o == op_rd) && data_ready;
            @(posedge clk_50mhz);
        end
    endtask

    task automatic set_flags(input logic dr, input logic tb, input logic ts, input logic [7:0] b);
        @(negedge clk_50mhz);
        en         = 1'b0;        // drop any held request
        chk_on     = 1'b0;
        data_ready = dr;
        tbre       = tb;
        tsre       = ts;
        com_byte   = b;
    endtask

    function automatic logic [addr_w-1:0] rand_high_addr();
        logic [addr_w-1:0] a;
        do
            a = 18'($urandom_range(32'h3FFFF, 32'h08000));
        while (a == 18'h0BF00 || a == 18'h0BF01);
        return a;
    endfunction

    initial
    begin
        logic [addr_w-1:0] a;
        logic [data_w-1:0] d;

        rst_n      = 1'b0;
        en         = 1'b0;
        op         = op_rd;
        addr       = '0;
        data_i     = '0;
        pc         = '0;
        data_ready = 1'b0;
        tbre       = 1'b0;
        tsre       = 1'b0;
        com_byte   = 8'h00;
        chk_on     = 1'b0;
        chk_data   = 1'b0;
        chk_inst   = 1'b0;
        exp_pause  = 1'b0;
        exp_data   = '0;
        exp_inst   = '0;
        void'($urandom(32'he02c_c724));

        repeat (16) @(posedge clk_50mhz);
        @(negedge clk_50mhz);
        rst_n = 1'b1;

        checker_i.start_test();
        for (int i = 0; i < n_rand; i++)
        begin
            a = rand_high_addr();
            addrs.push_back(a);
            access(1'b1, op_wr, a, 16'($urandom), 16'h0000);
        end
        foreach (addrs[i])
            access(1'b1, op_rd, addrs[i], 16'h0000, 16'h0000);
        checker_i.end_test("bank 0 write and read");

        checker_i.start_test();
        for (int i = 0; i < n_rand; i++)
            access(1'b0, op_rd, '0, '0, 16'($urandom));
        checker_i.end_test("instruction fetch");

        checker_i.start_test();
        for (int i = 0; i < 6; i++)
        begin
            a = 18'($urandom_range(32'h7FFF, 0));
            access(1'b1, op_wr, a, 16'($urandom), 16'h0000);
            access(1'b1, op_rd, a, 16'h0000, 16'h0000);
            access(1'b0, op_rd, '0, '0, a[15:0]);   // fetch sees the new word
        end
        checker_i.end_test("bank 1 data access");

        checker_i.start_test();
        for (int i = 0; i < 4; i++)
        begin
            d = 16'($urandom);
            access(1'b1, op_wr, 18'h0BF00, d, 16'h0000);
            checker_i.compare_word("serial write data", com_wr_data, d);
        end
        set_flags(1'b0, 1'b0, 1'b0, 8'h00);
        checker_i.check_strobes(0, 4, 1'b1);
        checker_i.end_test("serial write");

        checker_i.start_test();
        for (int i = 0; i < 3; i++)
        begin
            set_flags(1'b1, 1'b0, 1'b0, 8'($urandom));
            access(1'b1, op_rd, 18'h0BF00, 16'h0000, 16'h0000);
        end
        for (int i = 0; i < 2; i++)
        begin
            set_flags(1'b0, 1'b0, 1'b0, 8'($urandom));
            access(1'b1, op_rd, 18'h0BF00, 16'h0000, 16'h0000);
        end
        set_flags(1'b0, 1'b0, 1'b0, 8'h00);
        checker_i.check_strobes(3, 0, 1'b1);
        checker_i.end_test("serial read");

        checker_i.start_test();
        for (int i = 0; i < n_rand; i++)
        begin
            set_flags(1'($urandom), 1'($urandom), 1'($urandom), 8'h00);
            access(1'b1, op_rd, 18'h0BF01, 16'h0000, 16'h0000);
        end
        set_flags(1'b0, 1'b0, 1'b0, 8'h00);
        checker_i.end_test("serial status");

        $display("tests run %0d, failed %0d, errors %0d", run_tests, failed_tests, error_count);
        if (failed_tests == 0 && error_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    // generous bound derived from the number of tests
    initial
    begin
        repeat (2000 * num_tests) @(posedge clk_50mhz);
        $display("timeout: the tests did not finish in %0d cycles", 2000 * num_tests);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== verification/sram_model.sv ====
`timescale 1ns/1ps

module sram_model
    import mem_pkg::*;
#(
    parameter int unsigned bank    = 0,
    parameter bit          has_com = 1'b0    // serial device shares these lines
)
(
    input  sram_pins_t        pins,
    input  logic [data_w-1:0] data_out,
    input  logic              data_oe,
    output logic [data_w-1:0] data_in,
    input  logic              rdn,
    input  logic              wrn,
    input  logic [7:0]        com_byte,       // byte the device hands out on rdn
    output logic [data_w-1:0] com_wr_data     // last word seen at a wrn pulse
);

    logic [data_w-1:0] mem [2**addr_w];
    logic              we_n;

    // fill pattern spans every address bit, differs per bank
    function automatic logic [data_w-1:0] fill_word(input logic [addr_w-1:0] a);
        logic [data_w-1:0] salt;
        salt = (bank == 0) ? 16'h3c5a : 16'hc3a5;
        return a[15:0] ^ {a[1:0], a[17:4]} ^ salt;
    endfunction

    initial
    begin
        com_wr_data = '0;
        for (int i = 0; i < 2**addr_w; i++)
            mem[i] = fill_word(addr_w'(i));
    end

    assign we_n = pins.we_n;

    // write lands when we_n drops, address and data are stable then
    always @(negedge we_n)
    begin
        if (!pins.ce_n && data_oe)
            mem[pins.addr] <= data_out;
    end

    // device only sees the byte if the controller drives the shared bus
    always @(negedge wrn)
    begin
        if (has_com && data_oe)
            com_wr_data <= data_out;
    end

    assign data_in = (has_com && !rdn)            ? {8'h00, com_byte} :
                     (!pins.ce_n && !pins.oe_n)  ? mem[pins.addr]    :
                                                   '0;

endmodule
